// ==== verilog/rob_pkg.sv ====
// ROB package with sizes, tag and register index types
// Dispatch, CDB, retire and ROB entry structs
// Operand and register map read structs

package rob_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 32;
    localparam int ROB_DEPTH      = 8;
    localparam int TAG_WIDTH      = $clog2(ROB_DEPTH);
    localparam int REG_ADDR_WIDTH = 5;
    localparam int NUM_REGS       = 32;

    // ROB index, and a pointer with one extra wrap bit on top
    typedef logic [TAG_WIDTH-1:0]      tag_t;
    typedef logic [TAG_WIDTH:0]        ptr_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // A dispatched instruction; rdy means the result is already known
    typedef struct packed {
        logic                  en;
        logic                  rdy;
        logic [ADDR_WIDTH-1:0] iaddr;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        reg_addr_t             rdest;
        reg_addr_t [1:0]       rsrc;
    } dispatch_t;

    // A result broadcast on the common data bus
    // Redirect flags a taken branch, addr carries its target
    typedef struct packed {
        logic                  en;
        tag_t                  tag;
        logic [DATA_WIDTH-1:0] data;
        logic                  redirect;
        logic [ADDR_WIDTH-1:0] addr;
    } cdb_t;

    typedef struct packed {
        logic                  rdy;
        logic                  branch;
        logic [ADDR_WIDTH-1:0] iaddr;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        reg_addr_t             rdest;
    } rob_entry_t;

    // One instruction leaving the head of the ROB
    typedef struct packed {
        logic                  en;
        reg_addr_t             rdest;
        logic [DATA_WIDTH-1:0] data;
        tag_t                  tag;
    } retire_t;

    typedef struct packed {
        logic                  rdy;
        tag_t                  tag;
        logic [DATA_WIDTH-1:0] data;
    } operand_t;

    typedef struct packed {
        logic                  busy;
        tag_t                  tag;
        logic [DATA_WIDTH-1:0] data;
    } map_read_t;

endpackage

// ==== verilog/rob_ptr_counter.sv ====
// Head and tail pointers of the ROB with wrap bits
// Full and empty flags derived from the pointers

`timescale 1ns/1ns

module rob_ptr_counter (
    input  logic          clk,
    input  logic          n_rst,
    input  logic          alloc,
    input  logic          release_en,
    input  logic          clear,
    output rob_pkg::tag_t head_tag,
    output rob_pkg::tag_t tail_tag,
    output logic          full,
    output logic          empty
);

    import rob_pkg::*;

    // The extra top bit flips each time a pointer wraps around the array
    ptr_t head;
    ptr_t tail;

    assign head_tag = head[TAG_WIDTH-1:0];
    assign tail_tag = tail[TAG_WIDTH-1:0];

    // Same slot but different lap means the tail has caught up with the head
    assign full  = (head[TAG_WIDTH] != tail[TAG_WIDTH]) && (head_tag == tail_tag);
    assign empty = (head == tail);

    // A redirect squashes everything in flight, so clear wins over both moves
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            head <= '0;
            tail <= '0;
        end else if (clear) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (alloc) begin
                tail <= tail + ptr_t'(1);
            end
            if (release_en) begin
                head <= head + ptr_t'(1);
            end
        end
    end

    // The top level must never allocate into a full buffer
    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (!n_rst) !(alloc && full))
        else $error("ROB allocation while full");

endmodule

// ==== verilog/rob_entry_store.sv ====
// ROB entry array
// Dispatch write port at the tail and CDB write port at any tag
// Combinational read ports for the head and both source operands

`timescale 1ns/1ns

module rob_entry_store (
    input  logic                        clk,
    input  logic                        wr_en,
    input  rob_pkg::tag_t               wr_tag,
    input  rob_pkg::rob_entry_t         wr_entry,
    input  rob_pkg::cdb_t               cdb,
    input  logic                        cdb_accept,
    input  rob_pkg::tag_t               head_tag,
    output rob_pkg::rob_entry_t         head_entry,
    input  rob_pkg::tag_t [1:0]         rd_tag,
    output rob_pkg::rob_entry_t [1:0]   rd_entry
);

    import rob_pkg::*;

    rob_entry_t entries [ROB_DEPTH];
    rob_entry_t fill;

    // A fresh entry never starts as a taken branch
    // Only the CDB result can mark it as one
    always_comb begin
        fill        = wr_entry;
        fill.branch = 1'b0;
    end

    // Both ports may write in one cycle, always to different entries
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_tag] <= fill;
        end
        if (cdb_accept) begin
            entries[cdb.tag].rdy    <= 1'b1;
            entries[cdb.tag].branch <= cdb.redirect;
            entries[cdb.tag].data   <= cdb.data;
            entries[cdb.tag].addr   <= cdb.addr;
        end
    end

    // The head entry feeds retirement and the redirect decision
    assign head_entry = entries[head_tag];

    // Source lookups use the rename tags handed out by the register map
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rd_entry[i] = entries[rd_tag[i]];
        end
    end

    // A CDB result can only target an instruction dispatched in an earlier cycle
    a_write_ports_apart: assert property (
        @(posedge clk) (wr_en && cdb_accept) |-> (wr_tag != cdb.tag)
    ) else $error("Dispatch and CDB write the same ROB entry");

endmodule

// ==== verilog/register_map.sv ====
// Architectural register file of the core
// Busy bit and rename tag for each register
// Two combinational read ports for the source registers

`timescale 1ns/1ns

module register_map (
    input  logic                          clk,
    input  logic                          n_rst,
    input  rob_pkg::retire_t              retire,
    input  logic                          rename_en,
    input  rob_pkg::reg_addr_t            rename_reg,
    input  rob_pkg::tag_t                 rename_tag,
    input  logic                          clear_busy,
    input  rob_pkg::reg_addr_t [1:0]      rsrc,
    output rob_pkg::map_read_t [1:0]      rd
);

    import rob_pkg::*;

    logic [DATA_WIDTH-1:0] regs [NUM_REGS];
    tag_t                  tags [NUM_REGS];
    logic [NUM_REGS-1:0]   busy;

    logic retire_wr;
    logic rename_wr;

    // Register 0 is hardwired, so it is neither written nor renamed
    assign retire_wr = retire.en && (retire.rdest != '0);
    assign rename_wr = rename_en && (rename_reg != '0);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
                tags[r] <= '0;
            end
            busy <= '0;
        end else begin
            if (retire_wr) begin
                regs[retire.rdest] <= retire.data;
                // A younger writer may already own the register, keep it busy then
                if (tags[retire.rdest] == retire.tag) begin
                    busy[retire.rdest] <= 1'b0;
                end
            end
            // Placed after retire so that a same-cycle rename of that register wins
            if (rename_wr) begin
                busy[rename_reg] <= 1'b1;
                tags[rename_reg] <= rename_tag;
            end
            // After a squash no register waits on an in-flight result any more
            if (clear_busy) begin
                busy <= '0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rd[i].busy = (rsrc[i] != '0) && busy[rsrc[i]];
            rd[i].tag  = tags[rsrc[i]];
            rd[i].data = (rsrc[i] == '0) ? '0 : regs[rsrc[i]];
        end
    end

endmodule

// ==== verilog/operand_resolve.sv ====
// Source operand selection for a newly dispatched instruction
// Priority is register map, then same-cycle CDB, then ROB entry

`timescale 1ns/1ns

module operand_resolve (
    input  rob_pkg::map_read_t [1:0]   map_rd,
    input  rob_pkg::cdb_t              cdb,
    input  logic                       cdb_accept,
    input  rob_pkg::rob_entry_t [1:0]  rob_rd,
    output rob_pkg::operand_t [1:0]    operand
);

    // The tag always comes from the map, even when a value is available
    // Consumers ignore it once the operand is ready
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            operand[i].tag = map_rd[i].tag;
            if (!map_rd[i].busy) begin
                // No pending writer, the architectural value is current
                operand[i].rdy  = 1'b1;
                operand[i].data = map_rd[i].data;
            end else if (cdb_accept && (cdb.tag == map_rd[i].tag)) begin
                // The producer finishes right now, so the entry write is
                // not yet visible and the bus value has to be forwarded
                operand[i].rdy  = 1'b1;
                operand[i].data = cdb.data;
            end else begin
                // Either the entry already holds the result or the
                // instruction waits for this tag on the CDB
                operand[i].rdy  = rob_rd[i].rdy;
                operand[i].data = rob_rd[i].data;
            end
        end
    end

endmodule

// ==== verilog/flush_ctrl.sv ====
// Flush FSM that squashes the machine after a branch redirect
// Holds flushing for exactly one cycle

`timescale 1ns/1ns

module flush_ctrl (
    input  logic clk,
    input  logic n_rst,
    input  logic redirect,
    output logic flushing
);

    typedef enum logic {
        RUNNING,
        FLUSHING
    } state_t;

    state_t state;
    state_t next_state;

    // Squashed instructions may still broadcast in the single flush cycle
    // Dropping the CDB during that cycle is enough to keep them out
    always_comb begin
        next_state = state;
        case (state)
            RUNNING: begin
                if (redirect) begin
                    next_state = FLUSHING;
                end
            end
            FLUSHING: begin
                next_state = RUNNING;
            end
            default: begin
                next_state = RUNNING;
            end
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= RUNNING;
        end else begin
            state <= next_state;
        end
    end

    assign flushing = (state == FLUSHING);

endmodule

// ==== verilog/rob_core.sv ====
// Top level of the in-order completion subsystem
// Joins ROB pointers, entry store, register map, operand resolver and flush FSM
// Forms the dispatch accept, retire and redirect controls

`timescale 1ns/1ns

module rob_core (
    input  logic                               clk,
    input  logic                               n_rst,
    input  rob_pkg::dispatch_t                 dispatch,
    output logic                               stall,
    output rob_pkg::tag_t                      dispatch_tag,
    input  rob_pkg::cdb_t                      cdb,
    output rob_pkg::operand_t [1:0]            operand,
    output rob_pkg::retire_t                   retire,
    output logic                               redirect,
    output logic [rob_pkg::ADDR_WIDTH-1:0]     redirect_addr
);

    import rob_pkg::*;

    tag_t             head_tag;
    tag_t             tail_tag;
    logic             full;
    logic             empty;
    logic             flushing;
    logic             accept;
    logic             cdb_accept;
    rob_entry_t       wr_entry;
    rob_entry_t       head_entry;
    rob_entry_t [1:0] rob_rd;
    map_read_t [1:0]  map_rd;
    tag_t [1:0]       map_tag;

    // Dispatch is held off while the buffer is full or being squashed
    assign stall      = full || flushing;
    assign accept     = dispatch.en && !full && !flushing;
    assign cdb_accept = cdb.en && !flushing;

    // The head retires as soon as its result is known
    assign retire.en    = head_entry.rdy && !empty && !flushing;
    assign retire.rdest = head_entry.rdest;
    assign retire.data  = head_entry.data;
    assign retire.tag   = head_tag;

    // A retiring taken branch sends fetch to the branch target
    assign redirect      = retire.en && head_entry.branch;
    assign redirect_addr = head_entry.addr;

    // The new instruction always lands at the current tail
    assign dispatch_tag = tail_tag;

    assign wr_entry.rdy    = dispatch.rdy;
    assign wr_entry.branch = 1'b0;
    assign wr_entry.iaddr  = dispatch.iaddr;
    assign wr_entry.addr   = dispatch.addr;
    assign wr_entry.data   = dispatch.data;
    assign wr_entry.rdest  = dispatch.rdest;

    // Rename tags from the map select which ROB entries are read for the sources
    assign map_tag[0] = map_rd[0].tag;
    assign map_tag[1] = map_rd[1].tag;

    rob_ptr_counter rob_ptr_counter_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .alloc      (accept),
        .release_en (retire.en),
        .clear      (redirect),
        .head_tag   (head_tag),
        .tail_tag   (tail_tag),
        .full       (full),
        .empty      (empty)
    );

    rob_entry_store rob_entry_store_i (
        .clk        (clk),
        .wr_en      (accept),
        .wr_tag     (tail_tag),
        .wr_entry   (wr_entry),
        .cdb        (cdb),
        .cdb_accept (cdb_accept),
        .head_tag   (head_tag),
        .head_entry (head_entry),
        .rd_tag     (map_tag),
        .rd_entry   (rob_rd)
    );

    register_map register_map_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .retire     (retire),
        .rename_en  (accept),
        .rename_reg (dispatch.rdest),
        .rename_tag (tail_tag),
        .clear_busy (flushing),
        .rsrc       (dispatch.rsrc),
        .rd         (map_rd)
    );

    operand_resolve operand_resolve_i (
        .map_rd     (map_rd),
        .cdb        (cdb),
        .cdb_accept (cdb_accept),
        .rob_rd     (rob_rd),
        .operand    (operand)
    );

    flush_ctrl flush_ctrl_i (
        .clk      (clk),
        .n_rst    (n_rst),
        .redirect (redirect),
        .flushing (flushing)
    );

endmodule

// ==== testbench/rob_core_tb.sv ====
// Table-driven testbench for the ROB completion subsystem
// Reference model that fills in the expected values, value checks, watchdog and summary

`timescale 1ns/1ns

module rob_core_tb;

    import rob_pkg::*;

    localparam int          CLK_PERIOD    = 8;
    localparam int          RESET_CYCLES  = 8;
    localparam int          MARGIN_CYCLES = 16;
    localparam logic [31:0] SEED          = 32'h6f568865;

    // One row of the table: stimulus first, then what the DUT must show in that cycle
    typedef struct packed {
        dispatch_t             d;
        cdb_t                  c;
        logic                  stall;
        tag_t                  dtag;
        operand_t [1:0]        op;
        retire_t               ret;
        logic                  redir;
        logic [ADDR_WIDTH-1:0] raddr;
    } step_t;

    logic                  clk;
    logic                  n_rst;
    dispatch_t             dispatch;
    cdb_t                  cdb;
    logic                  stall;
    tag_t                  dispatch_tag;
    operand_t [1:0]        operand;
    retire_t               retire;
    logic                  redirect;
    logic [ADDR_WIDTH-1:0] redirect_addr;

    step_t steps[$];
    int    errors;
    int    checks;
    int    cur_step;

    // Reference model state: in-flight tags in program order, entries and the register map
    tag_t                  inflight[$];
    tag_t                  m_tail;
    logic                  m_flush;
    rob_entry_t            m_entry [ROB_DEPTH];
    logic [DATA_WIDTH-1:0] m_regs [NUM_REGS];
    tag_t                  m_tags [NUM_REGS];
    logic [NUM_REGS-1:0]   m_busy;

    rob_core rob_core_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .dispatch      (dispatch),
        .stall         (stall),
        .dispatch_tag  (dispatch_tag),
        .cdb           (cdb),
        .operand       (operand),
        .retire        (retire),
        .redirect      (redirect),
        .redirect_addr (redirect_addr)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Appends one step, data values and addresses are random
    task automatic add_step(input logic den, input logic drdy, input reg_addr_t rdest,
                            input reg_addr_t rs0, input reg_addr_t rs1,
                            input logic cen, input tag_t ctag, input logic cbr);
        step_t st;
        st             = '0;
        st.d.en        = den;
        st.d.rdy       = drdy;
        st.d.iaddr     = ADDR_WIDTH'(steps.size() * 4);
        st.d.addr      = $urandom();
        st.d.data      = $urandom();
        st.d.rdest     = rdest;
        st.d.rsrc[0]   = rs0;
        st.d.rsrc[1]   = rs1;
        st.c.en        = cen;
        st.c.tag       = ctag;
        st.c.data      = $urandom();
        st.c.redirect  = cbr;
        st.c.addr      = $urandom();
        steps.push_back(st);
    endtask

    task automatic build_table();
        // Idle cycle straight after reset, registers read as zero
        add_step(0, 0, 0, 5, 3, 0, 0, 0);
        // Three writers, results come back as tags 1, 2, 0 and retire as 0, 1, 2
        add_step(1, 0, 1, 0, 0, 0, 0, 0);
        add_step(1, 0, 2, 1, 0, 0, 0, 0);
        add_step(1, 0, 3, 1, 2, 1, 1, 0);
        add_step(0, 0, 0, 2, 3, 1, 2, 0);
        // Both sources come from entries that already hold results
        add_step(1, 0, 4, 2, 3, 0, 0, 0);
        add_step(0, 0, 0, 1, 4, 1, 0, 0);
        add_step(0, 0, 0, 1, 0, 1, 3, 0);
        add_step(0, 0, 0, 1, 2, 0, 0, 0);
        add_step(0, 0, 0, 0, 0, 0, 0, 0);
        add_step(0, 0, 0, 0, 0, 0, 0, 0);
        add_step(0, 0, 0, 0, 0, 0, 0, 0);
        // Fill all eight entries with pending results, tags 4 to 3
        for (int k = 0; k < ROB_DEPTH; k++) begin
            add_step(1, 0, reg_addr_t'(5 + k), 0, 0, 0, 0, 0);
        end
        // The ninth dispatch is held until tag 4 retires, then takes tag 4
        add_step(1, 0, 13, 5, 12, 0, 0, 0);
        add_step(1, 0, 13, 5, 12, 1, 4, 0);
        add_step(1, 0, 13, 5, 12, 0, 0, 0);
        add_step(1, 0, 13, 5, 12, 0, 0, 0);
        // Tag 6 is a taken branch and squashes everything younger
        add_step(0, 0, 0, 6, 7, 1, 5, 0);
        add_step(0, 0, 0, 6, 7, 1, 6, 1);
        add_step(0, 0, 0, 7, 8, 1, 7, 0);
        // Flush cycle, the CDB broadcast for tag 0 has to be dropped
        add_step(1, 0, 14, 9, 10, 1, 0, 0);
        add_step(1, 1, 2, 9, 7, 0, 0, 0);
        // Rename of r2 in the same cycle as the retire of its old writer
        add_step(1, 0, 2, 2, 1, 0, 0, 0);
        add_step(0, 0, 0, 2, 0, 0, 0, 0);
        add_step(0, 0, 0, 2, 0, 1, 1, 0);
        add_step(0, 0, 0, 2, 13, 0, 0, 0);
        add_step(0, 0, 0, 2, 0, 0, 0, 0);
        // Two writers of r3, the older one retires while the younger keeps r3 busy
        add_step(1, 0, 3, 0, 0, 0, 0, 0);
        add_step(1, 0, 3, 0, 0, 1, 2, 0);
        add_step(0, 0, 0, 3, 0, 0, 0, 0);
        add_step(0, 0, 0, 3, 0, 0, 0, 0);
    endtask

    // Walks the table through the model and stores the expected outputs in each row
    task automatic predict_all();
        step_t     st;
        tag_t      h;
        tag_t      src_tag;
        reg_addr_t r;
        logic      full;
        logic      acc;
        logic      cacc;
        logic      ret;
        logic      redir;
        inflight.delete();
        m_tail  = '0;
        m_flush = 1'b0;
        m_busy  = '0;
        for (int k = 0; k < NUM_REGS; k++) begin
            m_regs[k] = '0;
            m_tags[k] = '0;
        end
        for (int k = 0; k < ROB_DEPTH; k++) begin
            m_entry[k] = '0;
        end
        foreach (steps[i]) begin
            st    = steps[i];
            full  = (inflight.size() == ROB_DEPTH);
            h     = (inflight.size() != 0) ? inflight[0] : '0;
            acc   = st.d.en && !full && !m_flush;
            cacc  = st.c.en && !m_flush;
            ret   = (inflight.size() != 0) && m_entry[h].rdy && !m_flush;
            redir = ret && m_entry[h].branch;
            st.stall = full || m_flush;
            st.dtag  = m_tail;
            // Map first, then the bus in this cycle, then the producer's entry
            for (int k = 0; k < 2; k++) begin
                r             = st.d.rsrc[k];
                src_tag       = m_tags[r];
                st.op[k].tag  = src_tag;
                if (r == '0 || !m_busy[r]) begin
                    st.op[k].rdy  = 1'b1;
                    st.op[k].data = m_regs[r];
                end else if (cacc && st.c.tag == src_tag) begin
                    st.op[k].rdy  = 1'b1;
                    st.op[k].data = st.c.data;
                end else begin
                    st.op[k].rdy  = m_entry[src_tag].rdy;
                    st.op[k].data = m_entry[src_tag].data;
                end
            end
            st.ret.en    = ret;
            st.ret.rdest = m_entry[h].rdest;
            st.ret.data  = m_entry[h].data;
            st.ret.tag   = h;
            st.redir     = redir;
            st.raddr     = m_entry[h].addr;
            // State update at the clock edge that ends this step
            if (ret && m_entry[h].rdest != '0) begin
                m_regs[m_entry[h].rdest] = m_entry[h].data;
                if (m_tags[m_entry[h].rdest] == h) begin
                    m_busy[m_entry[h].rdest] = 1'b0;
                end
            end
            if (acc && st.d.rdest != '0) begin
                m_busy[st.d.rdest] = 1'b1;
                m_tags[st.d.rdest] = m_tail;
            end
            if (m_flush) begin
                m_busy = '0;
            end
            if (acc) begin
                m_entry[m_tail] = {st.d.rdy, 1'b0, st.d.iaddr, st.d.addr, st.d.data, st.d.rdest};
            end
            if (cacc) begin
                m_entry[st.c.tag].rdy    = 1'b1;
                m_entry[st.c.tag].branch = st.c.redirect;
                m_entry[st.c.tag].data   = st.c.data;
                m_entry[st.c.tag].addr   = st.c.addr;
            end
            if (redir) begin
                inflight.delete();
                m_tail = '0;
            end else begin
                if (ret) begin
                    void'(inflight.pop_front());
                end
                if (acc) begin
                    inflight.push_back(m_tail);
                    m_tail = tag_t'(m_tail + 1);
                end
            end
            m_flush  = redir;
            steps[i] = st;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t step %0d: %s is %h, expected %h",
                     $time, cur_step, name, actual, expected);
        end
    endtask

    // Data and tags only matter where the matching valid bit says so
    task automatic compare_outputs(input step_t st);
        check_value("stall", 32'(stall), 32'(st.stall));
        check_value("dispatch_tag", 32'(dispatch_tag), 32'(st.dtag));
        for (int k = 0; k < 2; k++) begin
            check_value($sformatf("operand[%0d].rdy", k), 32'(operand[k].rdy),
                        32'(st.op[k].rdy));
            if (st.op[k].rdy) begin
                check_value($sformatf("operand[%0d].data", k), operand[k].data, st.op[k].data);
            end else begin
                check_value($sformatf("operand[%0d].tag", k), 32'(operand[k].tag),
                            32'(st.op[k].tag));
            end
        end
        check_value("retire.en", 32'(retire.en), 32'(st.ret.en));
        if (st.ret.en) begin
            check_value("retire.rdest", 32'(retire.rdest), 32'(st.ret.rdest));
            check_value("retire.data", retire.data, st.ret.data);
            check_value("retire.tag", 32'(retire.tag), 32'(st.ret.tag));
        end
        check_value("redirect", 32'(redirect), 32'(st.redir));
        if (st.redir) begin
            check_value("redirect_addr", redirect_addr, st.raddr);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        errors   = 0;
        checks   = 0;
        cur_step = 0;
        n_rst    = 1'b0;
        dispatch = '0;
        cdb      = '0;
        build_table();
        predict_all();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 n_rst = 1'b1;
        // Inputs change 1 ns after the edge, outputs are sampled late in the cycle
        foreach (steps[i]) begin
            @(posedge clk);
            #1;
            cur_step = i;
            dispatch = steps[i].d;
            cdb      = steps[i].c;
            #5;
            compare_outputs(steps[i]);
        end
        @(posedge clk);
        #1;
        dispatch = '0;
        cdb      = '0;
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // The table is built at time zero, so its length is known after the first step
    initial begin
        #1;
        #((steps.size() + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== src.f ====
verilog/rob_pkg.sv
verilog/rob_ptr_counter.sv
verilog/rob_entry_store.sv
verilog/register_map.sv
verilog/operand_resolve.sv
verilog/flush_ctrl.sv
verilog/rob_core.sv
testbench/rob_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the ROB testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module rob_core_tb \
    -Mdir obj_dir -o rob_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rob_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
